//--- source/mine_pkg.sv
// Minesweeper shared types: level and state enums, cell, click, config and status structs.
package mine_pkg;

  // ========================================
  // Enums
  // ========================================

  // Level code follows the button decode {btn1|btn0, btn2|btn0}.
  typedef enum logic [1:0] {
    LVL_EASY   = 2'b01,
    LVL_MEDIUM = 2'b10,
    LVL_HARD   = 2'b11
  } level_e;

  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_RUN  = 2'b01,
    ST_LOST = 2'b10,
    ST_WON  = 2'b11
  } game_state_e;

  // ========================================
  // Structs
  // ========================================

  typedef struct packed {
    logic       mine;
    logic       revealed;
    logic       flagged;
    logic       spare;     // Always zero.
    logic [3:0] nbr;       // Mines among the eight neighbours.
  } cell_t;

  typedef struct packed {
    logic [3:0] x;
    logic [3:0] y;
    logic       left;      // One-cycle pulse.
    logic       right;     // One-cycle pulse.
  } click_t;

  typedef struct packed {
    level_e     level;
    logic [4:0] side;      // 8, 10 or 16.
    logic [7:0] start_sec;
  } game_cfg_t;

  typedef struct packed {
    game_state_e state;
    logic        explode;
    logic [5:0]  mines_left;
    logic [7:0]  seconds_left;
  } status_t;

  // ========================================
  // Constants
  // ========================================

  localparam int MAX_SIDE = 16;
  localparam logic [8:0] STATUS_ADDR = 9'h100;

  // Indexed by level code. Entry 0 is never selected, kept equal to easy.
  localparam logic [3:0][4:0] SIDE_TBL = {5'd16, 5'd10, 5'd8, 5'd8};
  localparam logic [3:0][7:0] SECS_TBL = {8'd150, 8'd90, 8'd60, 8'd60};

endpackage

//--- source/game_setup.sv
// Game setup: level decode from the buttons, level latch and the game FSM.
module game_setup (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [2:0]              btn,
  input  logic                    time_elapsed,
  input  logic                    explode,
  input  logic                    all_clear,
  output mine_pkg::game_cfg_t     cfg,
  output mine_pkg::game_state_e   state,
  output logic                    game_over,
  output logic                    won
);

  logic                any_btn;
  mine_pkg::level_e    lvl_sel;
  mine_pkg::game_cfg_t cfg_sel;
  mine_pkg::game_cfg_t cfg_q;

  assign any_btn = |btn;

  // Same decode as the board buttons: btn2 easy, btn1 medium, btn0 hard.
  always_comb begin
    lvl_sel           = mine_pkg::level_e'({btn[1] | btn[0], btn[2] | btn[0]});
    cfg_sel.level     = lvl_sel;
    cfg_sel.side      = mine_pkg::SIDE_TBL[lvl_sel];
    cfg_sel.start_sec = mine_pkg::SECS_TBL[lvl_sel];
  end

  // The pressed level shows through while leaving idle, so the timer loads it on time.
  assign cfg = (state == mine_pkg::ST_IDLE && any_btn) ? cfg_sel : cfg_q;

  // ========================================
  // Level latch and FSM
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state           <= mine_pkg::ST_IDLE;
      cfg_q.level     <= mine_pkg::LVL_EASY;
      cfg_q.side      <= mine_pkg::SIDE_TBL[mine_pkg::LVL_EASY];
      cfg_q.start_sec <= mine_pkg::SECS_TBL[mine_pkg::LVL_EASY];
    end else begin
      case (state)
        mine_pkg::ST_IDLE: begin
          if (any_btn) begin
            state <= mine_pkg::ST_RUN;
            cfg_q <= cfg_sel;  // Level fixed for the rest of the game.
          end
        end
        mine_pkg::ST_RUN: begin
          if (explode || time_elapsed) begin
            state <= mine_pkg::ST_LOST;
          end else if (all_clear) begin
            state <= mine_pkg::ST_WON;
          end
        end
        default: state <= state;  // Lost and won hold until reset.
      endcase
    end
  end

  assign game_over = (state == mine_pkg::ST_LOST);
  assign won       = (state == mine_pkg::ST_WON);

endmodule

//--- source/mine_field.sv
// Mine field: cell storage, click handling, neighbour count, counters, win and explode.
module mine_field (
  input  logic                  clk,
  input  logic                  arst_n,
  input  mine_pkg::game_cfg_t   cfg,
  input  mine_pkg::game_state_e state,
  input  mine_pkg::click_t      click,
  input  logic                  load_we,
  input  logic [7:0]            load_addr,
  input  logic                  load_mine,
  input  logic [7:0]            rd_addr,
  output mine_pkg::cell_t       rd_cell,
  output logic                  explode,
  output logic                  all_clear,
  output logic [5:0]            mines_left
);

  localparam int CELLS = mine_pkg::MAX_SIDE * mine_pkg::MAX_SIDE;

  logic [CELLS-1:0] mine_q;
  logic [CELLS-1:0] revealed_q;
  logic [CELLS-1:0] flagged_q;
  logic [3:0]       nbr_mem [CELLS];

  logic [8:0] mine_cnt [4];  // Loaded mines inside each level's square.
  logic [8:0] flag_cnt;
  logic [8:0] rev_cnt;       // Revealed safe cells.

  logic [7:0] click_addr;
  logic       in_side;
  logic       load_ok;
  logic       reveal;
  logic       flag_tgl;
  logic [3:0] nbr_cnt;
  logic [8:0] mines_sel;
  logic [8:0] safe_cells;
  logic [9:0] left_diff;

  assign click_addr = {click.y, click.x};
  assign in_side    = ({1'b0, click.x} < cfg.side) && ({1'b0, click.y} < cfg.side);
  assign load_ok    = load_we && (state == mine_pkg::ST_IDLE);
  assign reveal     = click.left && in_side && !revealed_q[click_addr]
                      && !flagged_q[click_addr];
  assign flag_tgl   = click.right && !click.left && in_side && !revealed_q[click_addr];

  // ========================================
  // Neighbour count
  // ========================================

  always_comb begin
    int nx;
    int ny;
    nbr_cnt = 4'd0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        nx = int'(click.x) + dx;
        ny = int'(click.y) + dy;
        if ((dx != 0 || dy != 0) && nx >= 0 && ny >= 0
            && nx < int'(cfg.side) && ny < int'(cfg.side)) begin
          nbr_cnt = nbr_cnt + 4'(mine_q[8'(ny * mine_pkg::MAX_SIDE + nx)]);
        end
      end
    end
  end

  // ========================================
  // Cell state and counters
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mine_q     <= '0;
      revealed_q <= '0;
      flagged_q  <= '0;
      flag_cnt   <= '0;
      rev_cnt    <= '0;
      explode    <= 1'b0;
      for (int i = 0; i < 4; i++) begin
        mine_cnt[i] <= '0;
      end
    end else begin
      if (load_ok) begin
        mine_q[load_addr] <= load_mine;
        for (int i = 0; i < 4; i++) begin
          if ({1'b0, load_addr[3:0]} < mine_pkg::SIDE_TBL[i]
              && {1'b0, load_addr[7:4]} < mine_pkg::SIDE_TBL[i]) begin
            if (load_mine && !mine_q[load_addr]) begin
              mine_cnt[i] <= mine_cnt[i] + 9'd1;
            end else if (!load_mine && mine_q[load_addr]) begin
              mine_cnt[i] <= mine_cnt[i] - 9'd1;
            end
          end
        end
      end
      if (reveal) begin
        revealed_q[click_addr] <= 1'b1;
        if (mine_q[click_addr]) explode <= 1'b1;  // Stays set until reset.
        else rev_cnt <= rev_cnt + 9'd1;
      end else if (flag_tgl) begin
        flagged_q[click_addr] <= !flagged_q[click_addr];
        if (flagged_q[click_addr]) flag_cnt <= flag_cnt - 9'd1;
        else flag_cnt <= flag_cnt + 9'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reveal) nbr_mem[click_addr] <= nbr_cnt;
  end

  // ========================================
  // Outputs
  // ========================================

  assign mines_sel  = mine_cnt[cfg.level];
  assign safe_cells = 9'(cfg.side * cfg.side) - mines_sel;
  assign all_clear  = (rev_cnt == safe_cells);
  assign left_diff  = {1'b0, mines_sel} - {1'b0, flag_cnt};

  always_comb begin
    if (left_diff[9]) mines_left = 6'd0;              // More flags than mines.
    else if (left_diff > 10'd63) mines_left = 6'd63;
    else mines_left = left_diff[5:0];
  end

  always_comb begin
    rd_cell.mine     = mine_q[rd_addr];
    rd_cell.revealed = revealed_q[rd_addr];
    rd_cell.flagged  = flagged_q[rd_addr];
    rd_cell.spare    = 1'b0;
    rd_cell.nbr      = revealed_q[rd_addr] ? nbr_mem[rd_addr] : 4'd0;
  end

endmodule

//--- source/wb_field_port.sv
// Wishbone classic slave mapping the cell array and the status word for the host.
module wb_field_port (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [8:0]            adr,
  input  logic [7:0]            dat_w,
  output logic [31:0]           dat_r,
  output logic                  ack,
  input  mine_pkg::game_state_e state,
  input  mine_pkg::cell_t       rd_cell,
  input  mine_pkg::status_t     status,
  output logic                  load_we,
  output logic [7:0]            load_addr,
  output logic                  load_mine,
  output logic [7:0]            rd_addr
);

  logic        req;
  logic        is_cell;
  logic [31:0] rd_mux;

  // New request only while ack is low, which gives the single-cycle ack.
  assign req     = cyc && stb && !ack;
  assign is_cell = !adr[8];

  assign rd_addr   = adr[7:0];
  assign load_addr = adr[7:0];
  assign load_mine = dat_w[0];
  assign load_we   = req && we && is_cell && (state == mine_pkg::ST_IDLE);  // Idle only.

  // ========================================
  // Read decode
  // ========================================

  always_comb begin
    if (is_cell) begin
      rd_mux = {24'd0, rd_cell};
    end else if (adr == mine_pkg::STATUS_ADDR) begin
      rd_mux = {15'd0, status};
    end else begin
      rd_mux = 32'd0;  // Unmapped.
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) dat_r <= rd_mux;  // Valid while ack is high.
  end

endmodule

//--- source/game_timer.sv
// Game timer: second prescaler, countdown and click gating outside the run state.
module game_timer #(
  parameter int TICKS_PER_SEC = 100_000_000
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  mine_pkg::game_cfg_t   cfg,
  input  mine_pkg::game_state_e state,
  input  logic                  tim_stop,
  input  mine_pkg::click_t      click,
  output mine_pkg::click_t      gated_click,
  output logic [7:0]            seconds_left,
  output logic                  time_elapsed
);

  localparam int PW = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

  logic [PW-1:0] presc;
  logic          sec_tick;
  logic          running;

  assign running  = (state == mine_pkg::ST_RUN);
  assign sec_tick = (presc == PW'(TICKS_PER_SEC - 1));

  // Clicks pass only while the game runs.
  always_comb begin
    gated_click       = click;
    gated_click.left  = click.left && running;
    gated_click.right = click.right && running;
  end

  // ========================================
  // Prescaler and countdown
  // ========================================

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      presc        <= '0;
      seconds_left <= 8'd0;
      time_elapsed <= 1'b0;
    end else if (state == mine_pkg::ST_IDLE) begin
      presc        <= '0;
      seconds_left <= cfg.start_sec;  // Preload, taken on the edge into run.
      time_elapsed <= 1'b0;
    end else if (running && !tim_stop && !time_elapsed) begin
      if (sec_tick) begin
        presc <= '0;
        if (seconds_left != 8'd0) seconds_left <= seconds_left - 8'd1;
        if (seconds_left == 8'd1) time_elapsed <= 1'b1;  // Last second gone.
      end else begin
        presc <= presc + 1'b1;
      end
    end
  end

endmodule

//--- source/disp_hex_mux.sv
// Four-digit hex seven-segment driver, time multiplexed, active-low outputs.
module disp_hex_mux #(
  parameter int REFRESH_BITS = 17
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic [3:0] hex3,
  input  logic [3:0] hex2,
  input  logic [3:0] hex1,
  input  logic [3:0] hex0,
  output logic [3:0] an,
  output logic [6:0] sseg
);

  logic [REFRESH_BITS+1:0] scan;
  logic [1:0]              sel;
  logic [3:0]              digit;
  logic [3:0]              an_nxt;
  logic [6:0]              seg_nxt;

  assign sel = scan[REFRESH_BITS+1:REFRESH_BITS];  // Top two bits pick the digit.

  always_comb begin
    case (sel)
      2'd0:    begin an_nxt = 4'b1110; digit = hex0; end
      2'd1:    begin an_nxt = 4'b1101; digit = hex1; end
      2'd2:    begin an_nxt = 4'b1011; digit = hex2; end
      default: begin an_nxt = 4'b0111; digit = hex3; end  // Leftmost.
    endcase
  end

  // Segment order {g,f,e,d,c,b,a}, low is lit.
  always_comb begin
    case (digit)
      4'h0: seg_nxt = 7'b1000000;
      4'h1: seg_nxt = 7'b1111001;
      4'h2: seg_nxt = 7'b0100100;
      4'h3: seg_nxt = 7'b0110000;
      4'h4: seg_nxt = 7'b0011001;
      4'h5: seg_nxt = 7'b0010010;
      4'h6: seg_nxt = 7'b0000010;
      4'h7: seg_nxt = 7'b1111000;
      4'h8: seg_nxt = 7'b0000000;
      4'h9: seg_nxt = 7'b0010000;
      4'ha: seg_nxt = 7'b0001000;
      4'hb: seg_nxt = 7'b0000011;
      4'hc: seg_nxt = 7'b1000110;
      4'hd: seg_nxt = 7'b0100001;
      4'he: seg_nxt = 7'b0000110;
      default: seg_nxt = 7'b0001110;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      scan <= '0;
      an   <= 4'b1111;  // All digits off.
      sseg <= 7'b1111111;
    end else begin
      scan <= scan + 1'b1;
      an   <= an_nxt;
      sseg <= seg_nxt;
    end
  end

endmodule

//--- source/mine_game_top.sv
// Minesweeper game core top level: setup, mine field, timer, host port and display.
module mine_game_top #(
  parameter int TICKS_PER_SEC = 100_000_000,
  parameter int REFRESH_BITS  = 17
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic [2:0]       btn,
  input  logic             tim_stop,
  input  mine_pkg::click_t click,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  logic [8:0]       adr,
  input  logic [7:0]       dat_w,
  output logic [31:0]      dat_r,
  output logic             ack,
  output logic [3:0]       an,
  output logic [6:0]       sseg,
  output logic             game_over,
  output logic             won
);

  // ========================================
  // Internal wires
  // ========================================

  mine_pkg::game_cfg_t   cfg;
  mine_pkg::game_state_e state;
  mine_pkg::click_t      gated_click;
  mine_pkg::cell_t       rd_cell;
  mine_pkg::status_t     status;

  logic [7:0] seconds_left;
  logic [5:0] mines_left;
  logic       time_elapsed, explode, all_clear;
  logic       load_we, load_mine;
  logic [7:0] load_addr, rd_addr;

  always_comb begin
    status.state        = state;
    status.explode      = explode;
    status.mines_left   = mines_left;
    status.seconds_left = seconds_left;
  end

  // ========================================
  // Blocks
  // ========================================

  game_setup u_game_setup (
    .clk, .arst_n, .btn, .time_elapsed, .explode, .all_clear,
    .cfg, .state, .game_over, .won
  );

  mine_field u_mine_field (
    .clk, .arst_n, .cfg, .state, .click(gated_click),
    .load_we, .load_addr, .load_mine, .rd_addr, .rd_cell,
    .explode, .all_clear, .mines_left
  );

  game_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_game_timer (
    .clk, .arst_n, .cfg, .state, .tim_stop, .click,
    .gated_click, .seconds_left, .time_elapsed
  );

  wb_field_port u_wb_field_port (
    .clk, .arst_n, .cyc, .stb, .we, .adr, .dat_w, .dat_r, .ack,
    .state, .rd_cell, .status, .load_we, .load_addr, .load_mine, .rd_addr
  );

  disp_hex_mux #(.REFRESH_BITS(REFRESH_BITS)) u_disp (
    .clk, .arst_n,
    .hex3({2'b00, mines_left[5:4]}), // Mines left on the two left digits.
    .hex2(mines_left[3:0]),
    .hex1(seconds_left[7:4]),
    .hex0(seconds_left[3:0]),
    .an, .sseg
  );

endmodule

//--- tb/clk_gen.sv
// Testbench clock and reset source, reset held low for a set number of cycles on request.
module clk_gen #(
  parameter int PERIOD     = 4,
  parameter int RST_CYCLES = 8
) (
  input  logic rst_req,
  output logic clk,
  output logic arst_n
);

  int rst_cnt;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n  = 1'b0;  // Reset from time zero.
    rst_cnt = RST_CYCLES;
  end

  always @(posedge clk) begin
    if (rst_req) begin
      arst_n  <= 1'b0;
      rst_cnt <= RST_CYCLES;
    end else if (rst_cnt > 0) begin
      rst_cnt <= rst_cnt - 1;
      if (rst_cnt == 1) arst_n <= 1'b1;  // Release after the last cycle.
    end
  end

endmodule

//--- tb/mine_game_assertions.sv
// Bound checks on the Wishbone ack and the game state rules of the minesweeper core.
module mine_game_assertions (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  cyc,
  input logic                  stb,
  input logic                  ack,
  input logic                  game_over,
  input logic                  won,
  input mine_pkg::game_state_e state
);

  ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
    else $error("ack stayed high for more than one cycle");

  ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(ack) |-> $past(cyc && stb))
    else $error("ack rose without a request on cyc and stb");

  end_exclusive: assert property (@(posedge clk) disable iff (!arst_n) !(game_over && won))
    else $error("game_over and won are high together");

  lost_holds: assert property (@(posedge clk) disable iff (!arst_n)
      state == mine_pkg::ST_LOST |=> state == mine_pkg::ST_LOST)
    else $error("state left lost before reset");

  won_holds: assert property (@(posedge clk) disable iff (!arst_n)
      state == mine_pkg::ST_WON |=> state == mine_pkg::ST_WON)
    else $error("state left won before reset");

endmodule

bind mine_game_top mine_game_assertions u_assert (
  .clk, .arst_n, .cyc, .stb, .ack, .game_over, .won, .state
);

//--- tb/mine_game_tb.sv
// Testbench for the minesweeper core: Wishbone host, clicks, reference model and checks.
module mine_game_tb;

  localparam int TICKS = 20;

  logic             clk, arst_n, rst_req;
  logic [2:0]       btn;
  logic             tim_stop;
  mine_pkg::click_t click;
  logic             cyc, stb, we;
  logic [8:0]       adr;
  logic [7:0]       dat_w;
  logic [31:0]      dat_r;
  logic             ack;
  logic [3:0]       an;
  logic [6:0]       sseg;
  logic             game_over, won;

  // Reference model of the board and the game.
  logic                  ref_mine [256];
  logic                  ref_rev  [256];
  logic                  ref_flag [256];
  int                    ref_side;
  mine_pkg::game_state_e ref_state;
  logic                  ref_explode;
  logic [7:0]            ref_secs;

  logic [31:0] seed;
  int          mism_errs, other_errs;
  string       name_q [$];
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];
  string       cmp_name;
  logic [31:0] cmp_got, cmp_exp;

  clk_gen #(.PERIOD(4), .RST_CYCLES(8)) u_clk_gen (.rst_req, .clk, .arst_n);

  mine_game_top #(.TICKS_PER_SEC(TICKS), .REFRESH_BITS(4)) dut_i (
    .clk, .arst_n, .btn, .tim_stop, .click, .cyc, .stb, .we, .adr, .dat_w,
    .dat_r, .ack, .an, .sseg, .game_over, .won
  );

  // ========================================
  // Reference functions
  // ========================================

  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic logic [3:0] count_neighbours(input int x, input int y);
    int n;
    n = 0;
    for (int dy = -1; dy <= 1; dy++) begin
      for (int dx = -1; dx <= 1; dx++) begin
        if ((dx != 0 || dy != 0) && x + dx >= 0 && y + dy >= 0
            && x + dx < ref_side && y + dy < ref_side) begin
          if (ref_mine[(y + dy) * 16 + x + dx]) n++;
        end
      end
    end
    return 4'(n);
  endfunction

  function automatic mine_pkg::cell_t expected_cell(input int a);
    mine_pkg::cell_t c;
    c.mine     = ref_mine[a];
    c.revealed = ref_rev[a];
    c.flagged  = ref_flag[a];
    c.spare    = 1'b0;
    c.nbr      = ref_rev[a] ? count_neighbours(a % 16, a / 16) : 4'd0;
    return c;
  endfunction

  function automatic logic [5:0] mines_left_model();
    int m;
    m = 0;
    for (int a = 0; a < 256; a++) begin
      if (ref_mine[a] && a % 16 < ref_side && a / 16 < ref_side) m++;
      if (ref_flag[a]) m--;
    end
    if (m < 0) m = 0;  // Saturates at zero.
    if (m > 63) m = 63;
    return 6'(m);
  endfunction

  function automatic mine_pkg::status_t expected_status();
    mine_pkg::status_t s;
    s.state        = ref_state;
    s.explode      = ref_explode;
    s.mines_left   = mines_left_model();
    s.seconds_left = ref_secs;
    return s;
  endfunction

  function automatic logic [3:0] expected_digit(input int pos);
    logic [5:0] ml;
    logic [3:0] h;
    ml = mines_left_model();
    case (pos)
      3:       h = {2'b00, ml[5:4]};
      2:       h = ml[3:0];
      1:       h = ref_secs[7:4];
      default: h = ref_secs[3:0];
    endcase
    return h;
  endfunction

  // Active-low {g,f,e,d,c,b,a} back to a hex value, 5'h10 when no digit matches.
  function automatic logic [4:0] seg_to_hex(input logic [6:0] seg);
    logic [4:0] h;
    case (seg)
      7'h40: h = 5'h0;
      7'h79: h = 5'h1;
      7'h24: h = 5'h2;
      7'h30: h = 5'h3;
      7'h19: h = 5'h4;
      7'h12: h = 5'h5;
      7'h02: h = 5'h6;
      7'h78: h = 5'h7;
      7'h00: h = 5'h8;
      7'h10: h = 5'h9;
      7'h08: h = 5'ha;
      7'h03: h = 5'hb;
      7'h46: h = 5'hc;
      7'h21: h = 5'hd;
      7'h06: h = 5'he;
      7'h0e: h = 5'hf;
      default: h = 5'h10;
    endcase
    return h;
  endfunction

  function automatic logic board_cleared();
    logic done;
    done = 1'b1;
    for (int a = 0; a < 256; a++) begin
      if (a % 16 < ref_side && a / 16 < ref_side && !ref_mine[a] && !ref_rev[a]) done = 1'b0;
    end
    return done;
  endfunction

  // ========================================
  // Compare process
  // ========================================

  task automatic push_check(input string name, input logic [31:0] got, input logic [31:0] exp);
    name_q.push_back(name);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  always @(posedge clk) begin
    while (got_q.size() > 0) begin
      cmp_name = name_q.pop_front();
      cmp_got  = got_q.pop_front();
      cmp_exp  = exp_q.pop_front();
      assert (cmp_got === cmp_exp) else begin
        mism_errs++;
        $display("mismatch %s: got %h, expected %h", cmp_name, cmp_got, cmp_exp);
      end
    end
  end

  // ========================================
  // Stimulus tasks
  // ========================================

  task automatic reset_model();
    for (int a = 0; a < 256; a++) begin
      ref_mine[a] = 1'b0;
      ref_rev[a]  = 1'b0;
      ref_flag[a] = 1'b0;
    end
    ref_side    = 8;  // Easy after reset.
    ref_state   = mine_pkg::ST_IDLE;
    ref_explode = 1'b0;
    ref_secs    = 8'd60;
  endtask

  task automatic wait_reset_release();
    int t;
    t = 0;
    while (!arst_n && t < 40) begin
      @(negedge clk);
      t++;
      if (!arst_n) begin
        push_check("an in reset", {28'd0, an}, 32'hf);
        push_check("ack in reset", {31'd0, ack}, 32'd0);
        push_check("game_over in reset", {30'd0, game_over, won}, 32'd0);
      end
    end
    if (!arst_n) begin
      other_errs++;
      $display("timeout: reset was never released");
    end
  endtask

  task automatic restart_game();
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    wait_reset_release();
    reset_model();
  endtask

  task automatic write_bus(input logic [8:0] a, input logic [7:0] d);
    int t;
    cyc   = 1'b1;
    stb   = 1'b1;
    we    = 1'b1;
    adr   = a;
    dat_w = d;
    @(negedge clk);
    t = 1;
    while (!ack && t < 20) begin
      @(negedge clk);
      t++;
    end
    if (!ack) begin
      other_errs++;
      $display("timeout: no ack for the write to address %h", a);
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
  endtask

  task automatic read_bus(input logic [8:0] a, output logic [31:0] d);
    int t;
    cyc = 1'b1;
    stb = 1'b1;
    we  = 1'b0;
    adr = a;
    @(negedge clk);
    t = 1;
    while (!ack && t < 20) begin
      @(negedge clk);
      t++;
    end
    d = ack ? dat_r : 32'd0;
    if (!ack) begin
      other_errs++;
      $display("timeout: no ack for the read of address %h", a);
    end
    cyc = 1'b0;
    stb = 1'b0;
  endtask

  task automatic check_cell(input int a);
    logic [31:0] d;
    read_bus(9'(a), d);
    push_check($sformatf("cell %02h", a), d, {24'd0, expected_cell(a)});
  endtask

  task automatic check_status();
    logic [31:0] d;
    read_bus(mine_pkg::STATUS_ADDR, d);
    push_check("status", d, {15'd0, expected_status()});
  endtask

  // Each digit is sampled while its anode is low.
  task automatic check_display();
    int t;
    logic [3:0] target;
    for (int pos = 0; pos < 4; pos++) begin
      target = ~(4'b0001 << pos);
      t = 0;
      while (an != target && t < 100) begin
        @(negedge clk);
        t++;
      end
      if (an != target) begin
        other_errs++;
        $display("timeout: digit %0d was never selected", pos);
      end else begin
        push_check($sformatf("sseg digit %0d", pos), {27'd0, seg_to_hex(sseg)},
                   {28'd0, expected_digit(pos)});
      end
    end
  endtask

  task automatic press_button(input logic [2:0] b, input int side, input logic [7:0] secs);
    btn = b;
    @(negedge clk);
    btn = 3'b000;
    ref_state = mine_pkg::ST_RUN;
    ref_side  = side;
    ref_secs  = secs;
  endtask

  task automatic click_cell(input int x, input int y, input logic l, input logic r);
    int a;
    a = y * 16 + x;
    click.x     = 4'(x);
    click.y     = 4'(y);
    click.left  = l;
    click.right = r;
    @(negedge clk);
    click.left  = 1'b0;
    click.right = 1'b0;
    @(negedge clk);
    if (ref_state == mine_pkg::ST_RUN && x < ref_side && y < ref_side) begin
      if (l && !ref_rev[a] && !ref_flag[a]) begin
        ref_rev[a] = 1'b1;
        if (ref_mine[a]) begin
          ref_explode = 1'b1;
          ref_state   = mine_pkg::ST_LOST;
        end
      end else if (r && !l && !ref_rev[a]) begin
        ref_flag[a] = !ref_flag[a];
      end
      if (ref_state == mine_pkg::ST_RUN && board_cleared()) ref_state = mine_pkg::ST_WON;
    end
  endtask

  task automatic wait_outcome(input logic want_won, input int limit);
    int t;
    t = 0;
    while (!(want_won ? won : game_over) && t < limit) begin
      @(negedge clk);
      t++;
    end
    if (!(want_won ? won : game_over)) begin
      other_errs++;
      $display("timeout: the game did not end as %s", want_won ? "won" : "lost");
    end
  endtask

  // ========================================
  // Test sequence
  // ========================================

  initial begin
    logic [31:0] r, s1, s2, s3, s4;
    rst_req    = 1'b0;
    btn        = 3'b000;
    tim_stop   = 1'b0;
    click      = '0;
    cyc        = 1'b0;
    stb        = 1'b0;
    we         = 1'b0;
    adr        = 9'd0;
    dat_w      = 8'd0;
    seed       = 32'h4273;
    mism_errs  = 0;
    other_errs = 0;
    reset_model();
    wait_reset_release();

    // Loading and readback while idle.
    tim_stop = 1'b1;  // Freezes the countdown.
    for (int a = 0; a < 256; a++) begin
      r = next_rand();
      ref_mine[a] = (r[2:0] == 3'd0);
    end
    ref_mine[8'h00] = 1'b0;
    ref_mine[8'h77] = 1'b1;
    for (int a = 0; a < 256; a++) write_bus(9'(a), {7'd0, ref_mine[a]});
    for (int a = 0; a < 256; a++) check_cell(a);
    check_status();
    read_bus(9'h1ff, r);
    push_check("unmapped read", r, 32'd0);

    press_button(3'b100, 8, 8'd60);
    check_status();
    write_bus(9'h000, 8'h01);  // Dropped outside idle.
    check_cell(8'h00);

    // Reveal row 0 and clicks outside the square.
    for (int x = 0; x < 8; x++) begin
      if (!ref_mine[x]) begin
        click_cell(x, 0, 1'b1, 1'b0);
        check_cell(x);
      end
    end
    click_cell(12, 3, 1'b1, 1'b0);
    check_cell(8'h3c);
    click_cell(3, 9, 1'b0, 1'b1);
    check_cell(8'h93);

    // Flags, the mine count and the display.
    click_cell(0, 7, 1'b0, 1'b1);
    click_cell(1, 7, 1'b0, 1'b1);
    click_cell(2, 7, 1'b0, 1'b1);
    click_cell(1, 7, 1'b0, 1'b1);
    for (int a = 8'h70; a < 8'h73; a++) check_cell(a);
    check_status();
    check_display();
    click_cell(0, 7, 1'b1, 1'b0);  // Flagged cell stays hidden.
    check_cell(8'h70);
    click_cell(0, 0, 1'b0, 1'b1);
    check_cell(8'h00);

    // Explosion.
    click_cell(7, 7, 1'b1, 1'b0);
    wait_outcome(1'b0, 20);
    check_status();
    check_cell(8'h77);
    click_cell(4, 4, 1'b1, 1'b0);
    click_cell(5, 5, 1'b0, 1'b1);
    check_cell(8'h44);
    check_cell(8'h55);
    push_check("won after explode", {31'd0, won}, 32'd0);

    // Time-out on the medium level.
    restart_game();
    tim_stop = 1'b0;
    press_button(3'b010, 10, 8'd90);
    read_bus(mine_pkg::STATUS_ADDR, s1);
    repeat (3 * TICKS) @(negedge clk);
    read_bus(mine_pkg::STATUS_ADDR, s2);
    assert (s2[7:0] < s1[7:0]) else begin
      other_errs++;
      $display("seconds_left did not count down while running");
    end
    tim_stop = 1'b1;
    @(negedge clk);
    read_bus(mine_pkg::STATUS_ADDR, s3);
    repeat (3 * TICKS) @(negedge clk);
    read_bus(mine_pkg::STATUS_ADDR, s4);
    push_check("seconds_left while stopped", {24'd0, s4[7:0]}, {24'd0, s3[7:0]});
    tim_stop = 1'b0;
    wait_outcome(1'b0, 100 * TICKS);
    ref_state = mine_pkg::ST_LOST;
    ref_secs  = 8'd0;
    check_status();
    push_check("won after time-out", {31'd0, won}, 32'd0);

    // Win on the easy level.
    restart_game();
    tim_stop = 1'b1;
    for (int a = 0; a < 256; a++) begin
      if (a % 16 < 8 && a / 16 < 8) begin
        r = next_rand();
        ref_mine[a] = (r[3:0] == 4'd0);
        write_bus(9'(a), {7'd0, ref_mine[a]});
      end
    end
    press_button(3'b100, 8, 8'd60);
    for (int a = 0; a < 128; a++) begin
      if (a % 16 < 8 && !ref_mine[a]) begin
        click_cell(a % 16, a / 16, 1'b1, 1'b0);
        check_cell(a);
      end
    end
    wait_outcome(1'b1, 20);
    check_status();
    push_check("game_over after win", {31'd0, game_over}, 32'd0);

    repeat (2) @(posedge clk);
    $display("checks done: %0d mismatches, %0d other errors", mism_errs, other_errs);
    if (mism_errs == 0 && other_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- mine_game.f
source/mine_pkg.sv
source/game_setup.sv
source/mine_field.sv
source/wb_field_port.sv
source/game_timer.sv
source/disp_hex_mux.sv
source/mine_game_top.sv
tb/clk_gen.sv
tb/mine_game_assertions.sv
tb/mine_game_tb.sv

//--- Makefile
VERILATOR  ?= verilator
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := mine_game_tb
RTL_TOP    := mine_game_top
FILELIST   := mine_game.f
LOG        := sim.log
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
